//--- Bender.yml
package:
  name: voice_path

sources:
  - files:
      - hw/voice_pkg.sv
      - hw/user_controls.sv
      - hw/noise_gate_stage.sv
      - hw/echo_stage.sv
      - hw/volume_stage.sv
      - hw/voice_path_top.sv
  - target: test
    files:
      - test/voice_path_checker.sv
      - test/voice_path_tb.sv

//--- filelist.f
hw/voice_pkg.sv
hw/user_controls.sv
hw/noise_gate_stage.sv
hw/echo_stage.sv
hw/volume_stage.sv
hw/voice_path_top.sv
test/voice_path_checker.sv
test/voice_path_tb.sv

//--- hw/echo_stage.sv
module echo_stage (
    input  logic               clk,
    input  logic               rst,
    input  voice_pkg::sample_t gate_data,
    input  logic               gate_valid,
    input  logic               advance,
    input  logic               effect,      // echo enabled
    output voice_pkg::sample_t echo_data,
    output logic               echo_valid
);

    voice_pkg::sample_t   delay_mem [voice_pkg::ECHO_DELAY];   // circular history
    voice_pkg::echo_idx_t wr_ptr;          // oldest entry, overwritten next
    voice_pkg::sample_t   delayed;         // sample from ECHO_DELAY samples ago
    voice_pkg::sample_t   echo_half;
    logic signed [16:0]   echo_sum;        // one guard bit for overflow
    voice_pkg::sample_t   echo_sat;
    voice_pkg::sample_t   stage_out;
    logic                 take;

    assign take = advance && gate_valid;

    // read before write, slot at wr_ptr is exactly ECHO_DELAY samples old
    assign delayed   = delay_mem[wr_ptr];
    assign echo_half = delayed >>> 1;   // half level, sign kept

    assign echo_sum = {gate_data[15], gate_data} + {echo_half[15], echo_half};

    // clamp to full scale when the two top bits disagree
    always_comb begin
        if (echo_sum[16] != echo_sum[15]) begin
            echo_sat = echo_sum[16] ? 16'sh8000 : 16'sh7fff;
        end else begin
            echo_sat = echo_sum[15:0];
        end
    end

    assign stage_out = effect ? echo_sat : gate_data;

    // history records every valid sample, with or without the effect
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < voice_pkg::ECHO_DELAY; i++) begin
                delay_mem[i] <= '0;   // echo of silence until filled
            end
            wr_ptr <= '0;
        end else if (take) begin
            delay_mem[wr_ptr] <= gate_data;
            if (wr_ptr == voice_pkg::echo_idx_t'(voice_pkg::ECHO_DELAY - 1)) begin
                wr_ptr <= '0;
            end else begin
                wr_ptr <= wr_ptr + 4'd1;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            echo_valid <= 1'b0;
        end else if (advance) begin
            echo_valid <= gate_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            echo_data <= stage_out;
        end
    end

endmodule

//--- hw/noise_gate_stage.sv
module noise_gate_stage (
    input  logic               clk,
    input  logic               rst,
    input  voice_pkg::sample_t sample_in,
    input  logic               sample_in_valid,
    input  logic               advance,       // pipeline may move this cycle
    input  logic               noise_gate,    // gating enabled
    input  logic               ptt,           // push-to-talk overrides the gate
    output logic               in_credit,     // one credit back per accepted sample
    output voice_pkg::sample_t gate_data,
    output logic               gate_valid
);

    typedef enum logic {
        GATE_CLOSED = 1'b0,
        GATE_OPEN   = 1'b1
    } gate_state_t;

    gate_state_t           state;
    gate_state_t           state_next;
    voice_pkg::hold_cnt_t  quiet_cnt;        // consecutive quiet samples, saturates
    voice_pkg::hold_cnt_t  quiet_cnt_next;
    voice_pkg::magnitude_t magnitude;
    logic                  loud;
    logic                  accept;
    logic                  silence;
    voice_pkg::sample_t    gated_sample;

    assign accept    = sample_in_valid && advance;
    assign in_credit = accept;   // source gets its credit in the accept cycle

    // two's complement magnitude, -32768 maps to 32768
    assign magnitude = sample_in[15] ? (~sample_in + 16'd1) : sample_in;
    assign loud      = magnitude >= voice_pkg::GATE_THRESHOLD;

    // hysteresis, gate stays open for GATE_HOLD quiet samples
    always_comb begin
        state_next     = state;
        quiet_cnt_next = quiet_cnt;
        if (loud) begin
            state_next     = GATE_OPEN;
            quiet_cnt_next = '0;
        end else if (quiet_cnt == voice_pkg::GATE_HOLD) begin
            state_next = GATE_CLOSED;   // hold time used up
        end else begin
            quiet_cnt_next = quiet_cnt + 4'd1;
        end
    end

    // gate tracks level even when gating is off
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= GATE_CLOSED;
            quiet_cnt <= voice_pkg::GATE_HOLD;   // starts fully timed out
        end else if (accept) begin
            state     <= state_next;
            quiet_cnt <= quiet_cnt_next;
        end
    end

    assign silence      = noise_gate && !ptt && (state_next == GATE_CLOSED);
    assign gated_sample = silence ? '0 : sample_in;

    // stage register, valid bit
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            gate_valid <= 1'b0;
        end else if (advance) begin
            gate_valid <= sample_in_valid;
        end
    end

    // stage register, payload
    always_ff @(posedge clk) begin
        if (accept) begin
            gate_data <= gated_sample;
        end
    end

endmodule

//--- hw/user_controls.sv
module user_controls (
    input  logic               clk,
    input  logic               rst,
    input  logic [3:0]         pbs,         // raw buttons, asynchronous
    input  logic [1:0]         vol,         // raw knob code, asynchronous
    output voice_pkg::volume_t volume,
    output logic               mute,
    output logic               effect,
    output logic               noise_gate,
    output logic               ptt
);

    logic [3:0]         pbs_meta;     // first sync flop
    logic [3:0]         pbs_sync;     // second sync flop, safe to use
    logic [3:0]         pbs_last;     // sync value one cycle back
    logic [3:0]         pbs_rise;     // one-cycle press pulses
    voice_pkg::knob_t   knob_meta;
    voice_pkg::knob_t   knob_sync;
    voice_pkg::knob_t   knob_last;
    logic               step_cw;      // one gray step clockwise
    logic               step_ccw;     // one gray step anticlockwise
    voice_pkg::volume_t volume_next;

    // two flop synchronizers for buttons and knob
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pbs_meta  <= '0;
            pbs_sync  <= '0;
            knob_meta <= voice_pkg::KNOB_00;
            knob_sync <= voice_pkg::KNOB_00;
        end else begin
            pbs_meta  <= pbs;
            pbs_sync  <= pbs_meta;
            knob_meta <= voice_pkg::knob_t'(vol);
            knob_sync <= knob_meta;
        end
    end

    // history for edge and step detection
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pbs_last  <= '0;
            knob_last <= voice_pkg::KNOB_00;
        end else begin
            pbs_last  <= pbs_sync;
            knob_last <= knob_sync;
        end
    end

    assign pbs_rise = pbs_sync & ~pbs_last;   // low to high on any button

    // mode flags, bit 0 is push-to-talk and is level sensitive
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mute       <= 1'b0;
            effect     <= 1'b0;
            noise_gate <= 1'b0;
            ptt        <= 1'b0;
        end else begin
            if (pbs_rise[1]) mute <= ~mute;
            if (pbs_rise[2]) effect <= ~effect;
            if (pbs_rise[3]) noise_gate <= ~noise_gate;
            ptt <= pbs_sync[0];   // held, not toggled
        end
    end

    // gray step decode on consecutive knob codes
    always_comb begin
        step_cw  = 1'b0;
        step_ccw = 1'b0;
        case ({knob_last, knob_sync})
            {voice_pkg::KNOB_00, voice_pkg::KNOB_01},
            {voice_pkg::KNOB_01, voice_pkg::KNOB_11},
            {voice_pkg::KNOB_11, voice_pkg::KNOB_10},
            {voice_pkg::KNOB_10, voice_pkg::KNOB_00}: step_cw = 1'b1;
            {voice_pkg::KNOB_00, voice_pkg::KNOB_10},
            {voice_pkg::KNOB_10, voice_pkg::KNOB_11},
            {voice_pkg::KNOB_11, voice_pkg::KNOB_01},
            {voice_pkg::KNOB_01, voice_pkg::KNOB_00}: step_ccw = 1'b1;
            default: ;   // no move, or a two-bit jump that is ignored
        endcase
    end

    // saturating volume counter
    always_comb begin
        volume_next = volume;
        if (step_cw && volume != 4'd15) begin
            volume_next = volume + 4'd1;
        end else if (step_ccw && volume != 4'd0) begin
            volume_next = volume - 4'd1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            volume <= '0;
        end else begin
            volume <= volume_next;
        end
    end

endmodule

//--- hw/voice_path_top.sv
module voice_path_top (
    input  logic               clk,
    input  logic               rst,
    input  voice_pkg::sample_t sample_in,
    input  logic               sample_in_valid,
    output logic               in_credit,
    output voice_pkg::sample_t sample_out,
    output logic               sample_out_valid,
    input  logic               out_credit,
    input  logic [3:0]         pbs,
    input  logic [1:0]         vol,
    output voice_pkg::volume_t volume,
    output logic               mute,
    output logic               effect,
    output logic               noise_gate,
    output logic               ptt
);

    voice_pkg::sample_t gate_data;    // gate to echo
    logic               gate_valid;
    voice_pkg::sample_t echo_data;    // echo to volume
    logic               echo_valid;
    logic               advance;      // from the credit owner to all stages

    user_controls u_controls (
        .clk        (clk),
        .rst        (rst),
        .pbs        (pbs),
        .vol        (vol),
        .volume     (volume),
        .mute       (mute),
        .effect     (effect),
        .noise_gate (noise_gate),
        .ptt        (ptt)
    );

    noise_gate_stage u_gate (
        .clk             (clk),
        .rst             (rst),
        .sample_in       (sample_in),
        .sample_in_valid (sample_in_valid),
        .advance         (advance),
        .noise_gate      (noise_gate),
        .ptt             (ptt),
        .in_credit       (in_credit),
        .gate_data       (gate_data),
        .gate_valid      (gate_valid)
    );

    echo_stage u_echo (
        .clk        (clk),
        .rst        (rst),
        .gate_data  (gate_data),
        .gate_valid (gate_valid),
        .advance    (advance),
        .effect     (effect),
        .echo_data  (echo_data),
        .echo_valid (echo_valid)
    );

    volume_stage u_volume (
        .clk              (clk),
        .rst              (rst),
        .echo_data        (echo_data),
        .echo_valid       (echo_valid),
        .out_credit       (out_credit),
        .mute             (mute),
        .volume           (volume),
        .advance          (advance),
        .sample_out       (sample_out),
        .sample_out_valid (sample_out_valid)
    );

endmodule

//--- hw/voice_pkg.sv
package voice_pkg;

    // pcm sample as carried between all stages
    typedef logic signed [15:0] sample_t;

    // unsigned magnitude of a sample, full range up to 32768
    typedef logic [15:0] magnitude_t;

    typedef logic [3:0] volume_t;     // 0 = silent, 15 = loudest
    typedef logic [3:0] hold_cnt_t;   // quiet sample counter in the gate
    typedef logic [3:0] echo_idx_t;   // delay line write pointer
    typedef logic [2:0] credit_t;     // enough for the deepest credit pool

    // quadrature knob positions in clockwise order
    typedef enum logic [1:0] {
        KNOB_00 = 2'b00,
        KNOB_01 = 2'b01,
        KNOB_11 = 2'b11,
        KNOB_10 = 2'b10
    } knob_t;

    // noise gate
    localparam magnitude_t GATE_THRESHOLD = 16'd512;   // opens at or above this level
    localparam hold_cnt_t  GATE_HOLD      = 4'd8;      // quiet samples passed before closing

    // echo
    localparam int ECHO_DELAY = 16;   // delay line depth in samples

    // flow control
    localparam credit_t OUT_CREDITS = 3'd4;   // sink credits owned by the pipeline at reset
    localparam credit_t IN_CREDITS  = 3'd2;   // source credits at reset

endpackage

//--- hw/volume_stage.sv
module volume_stage (
    input  logic               clk,
    input  logic               rst,
    input  voice_pkg::sample_t echo_data,
    input  logic               echo_valid,
    input  logic               out_credit,         // sink hands back one slot
    input  logic               mute,
    input  voice_pkg::volume_t volume,
    output logic               advance,            // whole pipeline steps
    output voice_pkg::sample_t sample_out,
    output logic               sample_out_valid
);

    voice_pkg::credit_t credits;       // free slots at the sink
    logic               credit_ok;
    logic               vol_full;      // output register holds a sample
    voice_pkg::sample_t vol_data;
    logic signed [20:0] product;       // 16 x 5 bit signed
    voice_pkg::sample_t scaled;
    voice_pkg::sample_t stage_out;

    assign credit_ok = credits != '0;

    // a held sample leaves as soon as a credit is there
    assign sample_out_valid = vol_full && credit_ok;
    assign sample_out       = vol_data;

    // move when the register drains this cycle or is empty
    assign advance = credit_ok || !vol_full;

    // volume/16 scaling, result always fits in 16 bits
    assign product   = echo_data * $signed({1'b0, volume});
    assign scaled    = product[19:4];
    assign stage_out = mute ? '0 : scaled;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            credits <= voice_pkg::OUT_CREDITS;
        end else begin
            case ({sample_out_valid, out_credit})
                2'b10:   credits <= credits - 3'd1;   // spent
                2'b01:   credits <= credits + 3'd1;   // returned
                default: ;                            // both or neither
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            vol_full <= 1'b0;
        end else if (advance) begin
            vol_full <= echo_valid;
        end
    end

    // mute and volume are taken as the sample enters this register
    always_ff @(posedge clk) begin
        if (advance && echo_valid) begin
            vol_data <= stage_out;
        end
    end

endmodule

//--- test/voice_path_checker.sv
module voice_path_checker (
    input logic               clk,
    input logic               rst,
    input voice_pkg::sample_t sample_in,
    input logic               sample_in_valid,
    input logic               in_credit,
    input voice_pkg::sample_t sample_out,
    input logic               sample_out_valid,
    input logic               out_credit,
    input logic [3:0]         pbs,
    input logic [1:0]         vol,
    input voice_pkg::volume_t volume,
    input logic               mute,
    input logic               effect,
    input logic               noise_gate,
    input logic               ptt
);

    int         err_cnt = 0;      // read by the testbench top
    int         out_cnt = 0;      // samples compared
    int         pending = 0;      // expected samples not yet seen
    int         exp_q[$];
    int         hist[$];          // gate outputs, oldest first
    logic [3:0] pbs_prev;
    logic [1:0] vol_prev;
    int         stable;           // cycles since last control change
    logic       m_mute, m_effect, m_ng, m_ptt;
    int         m_vol;
    logic       gate_open;
    int         quiet;
    int         src_credits;
    logic       src_busy;         // source has a sample waiting
    int         sink_credits;

    // clockwise position of a gray code
    function automatic int knob_pos(logic [1:0] k);
        case (k)
            2'b00:   return 0;
            2'b01:   return 1;
            2'b11:   return 2;
            default: return 3;
        endcase
    endfunction

    function automatic int clamp16(int v);
        if (v > 32767) return 32767;
        if (v < -32768) return -32768;
        return v;
    endfunction

    // gate, echo and volume applied in pipeline order
    task automatic model_sample(int x);
        int mag, g, d, e, v;
        mag = (x < 0) ? -x : x;
        if (mag >= int'(voice_pkg::GATE_THRESHOLD)) begin
            gate_open = 1'b1;
            quiet     = 0;
        end else if (quiet == int'(voice_pkg::GATE_HOLD)) begin
            gate_open = 1'b0;
        end else begin
            quiet++;
        end
        g = (m_ng && !m_ptt && !gate_open) ? 0 : x;
        d = hist.pop_front();
        hist.push_back(g);
        e = m_effect ? clamp16(g + (d >>> 1)) : g;
        v = m_mute ? 0 : ((e * m_vol) >>> 4);
        exp_q.push_back(v);
    endtask

    task automatic flag_err(string name, int got, int want);
        $display("ERR %0t: %s is %0d, expected %0d", $time, name, got, want);
        err_cnt++;
    endtask

    always @(negedge clk) begin
        int dir, got, want;
        if (rst) begin
            exp_q.delete();
            hist.delete();
            for (int i = 0; i < voice_pkg::ECHO_DELAY; i++) hist.push_back(0);
            {m_mute, m_effect, m_ng, m_ptt} = '0;
            m_vol        = 0;
            pbs_prev     = '0;
            vol_prev     = '0;
            stable       = 0;
            gate_open    = 1'b0;
            quiet        = int'(voice_pkg::GATE_HOLD);   // gate starts timed out
            src_credits  = int'(voice_pkg::IN_CREDITS);
            src_busy     = 1'b0;
            sink_credits = int'(voice_pkg::OUT_CREDITS);
        end else begin
            if (sample_in_valid && in_credit) model_sample(int'(sample_in));
            if (sample_in_valid && !src_busy) begin   // new transfer spends a credit
                src_busy = 1'b1;
                src_credits--;
                if (src_credits < 0) begin
                    $display("source sent a sample without holding a credit at %0t", $time);
                    err_cnt++;
                end
            end
            if (in_credit) begin
                src_busy = 1'b0;
                src_credits++;
                if (src_credits > int'(voice_pkg::IN_CREDITS)) begin
                    $display("in_credit overflowed the source credit pool at %0t", $time);
                    err_cnt++;
                end
            end
            if (sample_out_valid) begin
                sink_credits--;
                if (sink_credits < 0) begin
                    $display("sample_out_valid beyond the granted credits at %0t", $time);
                    err_cnt++;
                end
                if (exp_q.size() == 0) begin
                    $display("unexpected extra sample %0d at %0t", sample_out, $time);
                    err_cnt++;
                end else begin
                    want = exp_q.pop_front();
                    got  = int'(sample_out);
                    out_cnt++;
                    if (got != want) begin
                        $display("ERR %0t: sample_out %0d, expected %0d", $time, got, want);
                        err_cnt++;
                    end
                end
            end
            if (out_credit) begin
                sink_credits++;
                if (sink_credits > int'(voice_pkg::OUT_CREDITS)) begin
                    $display("sink returned more credits than it was given at %0t", $time);
                    err_cnt++;
                end
            end
            // control model, toggles on button edges, steps on knob changes
            if (pbs[1] && !pbs_prev[1]) m_mute = ~m_mute;
            if (pbs[2] && !pbs_prev[2]) m_effect = ~m_effect;
            if (pbs[3] && !pbs_prev[3]) m_ng = ~m_ng;
            m_ptt = pbs[0];
            dir = (knob_pos(vol) - knob_pos(vol_prev) + 4) % 4;
            if (dir == 1 && m_vol < 15) m_vol++;
            if (dir == 3 && m_vol > 0) m_vol--;
            stable   = (pbs != pbs_prev || vol != vol_prev) ? 0 : stable + 1;
            pbs_prev = pbs;
            vol_prev = vol;
            if (stable >= 5) begin   // flags settled after synchronizers
                if (mute != m_mute) flag_err("mute", mute, m_mute);
                if (effect != m_effect) flag_err("effect", effect, m_effect);
                if (noise_gate != m_ng) flag_err("noise_gate", noise_gate, m_ng);
                if (ptt != m_ptt) flag_err("ptt", ptt, m_ptt);
                if (int'(volume) != m_vol) flag_err("volume", volume, m_vol);
            end
        end
        pending = exp_q.size();
    end

endmodule

//--- test/voice_path_tb.sv
module voice_path_tb;

    localparam int PLANNED_SAMPLES = 8 + 30 + 60 + 200;   // mute, gate, echo and credit tests
    localparam int CLK_PERIOD      = 8;

    logic               clk = 1'b0;
    logic               rst = 1'b1;
    voice_pkg::sample_t sample_in = '0;
    logic               sample_in_valid = 1'b0;
    logic               in_credit;
    voice_pkg::sample_t sample_out;
    logic               sample_out_valid;
    logic               out_credit = 1'b0;
    logic [3:0]         pbs = '0;
    logic [1:0]         vol = '0;
    voice_pkg::volume_t volume;
    logic               mute, effect, noise_gate, ptt;

    int               seed = 32'h29291449;
    int               src_credits = int'(voice_pkg::IN_CREDITS);
    int               cycle = 0;
    int               due_q[$];       // cycles at which the sink returns credits
    int               err_mark = 0;
    voice_pkg::knob_t knob = voice_pkg::KNOB_00;

    always #(CLK_PERIOD / 2) clk = ~clk;

    voice_path_top DUT (.*);

    voice_path_checker chk (.*);

    // sink returns one credit per consumed sample after a random delay
    always @(negedge clk) begin
        logic [31:0] r;
        if (!rst && sample_out_valid) begin
            r = $random(seed);
            if (r[4:0] == 5'd0) due_q.push_back(cycle + 40 + int'(r[10:5]));   // long stall
            else due_q.push_back(cycle + 1 + int'(r[6:5]));
        end
    end

    always @(posedge clk) begin
        #1;
        cycle++;
        out_credit = 1'b0;
        if (!rst && due_q.size() > 0 && due_q[0] <= cycle) begin
            void'(due_q.pop_front());
            out_credit = 1'b1;
        end
    end

    task automatic wait_cycles(int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    // hold valid until the DUT takes the sample
    task automatic send_sample(int x);
        logic taken;
        while (src_credits == 0) wait_cycles(1);
        sample_in       = voice_pkg::sample_t'(x);
        sample_in_valid = 1'b1;
        src_credits--;
        taken = 1'b0;
        while (!taken) begin
            @(negedge clk);
            if (in_credit) begin
                taken = 1'b1;
                src_credits++;
            end
            wait_cycles(1);
        end
        sample_in_valid = 1'b0;
    endtask

    function automatic int rand_in_range(int lo, int hi);
        logic [31:0] r;
        r = $random(seed);
        return lo + int'(r % (hi - lo + 1));
    endfunction

    task automatic drain();
        while (chk.pending != 0) wait_cycles(1);
        wait_cycles(2);
    endtask

    task automatic press_button(int b);
        pbs[b] = 1'b1;
        wait_cycles(10);
        pbs[b] = 1'b0;
        wait_cycles(10);
    endtask

    task automatic turn_knob(logic cw);
        case (knob)
            voice_pkg::KNOB_00: knob = cw ? voice_pkg::KNOB_01 : voice_pkg::KNOB_10;
            voice_pkg::KNOB_01: knob = cw ? voice_pkg::KNOB_11 : voice_pkg::KNOB_00;
            voice_pkg::KNOB_11: knob = cw ? voice_pkg::KNOB_10 : voice_pkg::KNOB_01;
            default:            knob = cw ? voice_pkg::KNOB_00 : voice_pkg::KNOB_11;
        endcase
        vol = knob;
        wait_cycles(10);
    endtask

    task automatic test_done(string name);
        $display("test %s finished with %0d errors", name, chk.err_cnt - err_mark);
        err_mark = chk.err_cnt;
    endtask

    initial begin
        #((200 * PLANNED_SAMPLES + 2000) * CLK_PERIOD);
        $display("timeout, run did not finish with %0d samples outstanding", chk.pending);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        repeat (5) @(posedge clk);
        #1 rst = 1'b0;
        wait_cycles(10);
        repeat (20) turn_knob(1'b1);   // saturates at 15
        repeat (5) turn_knob(1'b0);
        knob = voice_pkg::knob_t'(~knob);   // two-bit jump is ignored
        vol  = knob;
        wait_cycles(10);
        test_done("reset_and_knob");

        press_button(1);
        repeat (8) send_sample(rand_in_range(-20000, 20000));   // muted
        drain();
        press_button(1);
        press_button(2);
        press_button(2);
        press_button(3);
        press_button(3);
        press_button(0);
        test_done("button_toggles");

        press_button(3);   // gate on
        repeat (6) send_sample(rand_in_range(1000, 30000));
        repeat (12) send_sample(rand_in_range(-400, 400));
        drain();
        pbs[0] = 1'b1;
        wait_cycles(10);
        repeat (12) send_sample(rand_in_range(-400, 400));
        drain();
        pbs[0] = 1'b0;
        wait_cycles(10);
        press_button(3);
        test_done("noise_gate");

        press_button(2);   // echo on
        repeat (20) send_sample(32767);
        repeat (20) send_sample(-32768);
        repeat (20) send_sample(rand_in_range(-32768, 32767));
        drain();
        press_button(2);
        test_done("echo");

        for (int i = 0; i < 200; i++) begin
            send_sample(rand_in_range(-32768, 32767));
            if (rand_in_range(0, 3) == 0) wait_cycles(rand_in_range(1, 6));
        end
        drain();
        test_done("credits");

        $display("%0d samples compared, %0d errors", chk.out_cnt, chk.err_cnt);
        if (chk.err_cnt == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule
